// ==== design/oldest_tracker.sv ====
/*
  oldest-event tracker
  keeps the oldest reported sequence number and its payload until flush
*/

`timescale 1ns/1ps

module oldest_tracker import seq_pkg::*; #(
  parameter int SEQ_NUM_BITS = $bits(seq_num_t),
  parameter int EPOCH_BITS = $bits(epoch_t),
  parameter type payload_t = logic
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  seq_report_if.tracker           rpt,
  seq_num_age_intf.age_user       age,
  output logic                    valid,
  output logic [SEQ_NUM_BITS-1:0] oldest_seq_num,
  output payload_t                oldest_payload
);

  // epoch slice has to leave room for a remainder
  if (EPOCH_BITS < 1 || EPOCH_BITS >= SEQ_NUM_BITS) begin : g_bad_widths
    $error("epoch field must be narrower than the sequence number");
  end

  logic ack_q;
  // report accepted on this edge
  logic take;
  // new report beats the stored one
  logic displace;

  assign rpt.ack = ack_q;

  // one accept per handshake, ack high blocks a second one
  assign take = rpt.req && !ack_q;

  // empty tracker takes anything
  assign displace = !valid || age.is_older(rpt.seq_num, oldest_seq_num);

  // ----------------------------------------------------------
  // four-phase responder
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (take) begin
      ack_q <= 1'b1;
    end else if (!rpt.req) begin
      // requester has let go
      ack_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // oldest entry
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (flush) begin
      // flush wins over a report on the same edge
      valid <= 1'b0;
    end else if (take && displace) begin
      valid <= 1'b1;
    end
  end

  // entry only meaningful while valid
  always_ff @(posedge clk) begin
    if (take && displace && !flush) begin
      oldest_seq_num <= rpt.seq_num;
      oldest_payload <= rpt.payload;
    end
  end

endmodule

// ==== design/seq_num_age_intf.sv ====
/*
  sequence-number age interface
  publishes the tail epoch and compares two numbers across counter wrap
*/

`timescale 1ns/1ps

interface seq_num_age_intf import seq_pkg::*; #(
  parameter int SEQ_NUM_BITS = $bits(seq_num_t),
  parameter int EPOCH_BITS = $bits(epoch_t)
) ();

  // epoch of the oldest live number, owned by the allocator
  logic [EPOCH_BITS-1:0] curr_tail_epoch;

  // ----------------------------------------------------------
  // age compare
  // ----------------------------------------------------------
  // epochs below the tail epoch belong to the next lap, so they
  // get an extra top bit before comparing

  function automatic logic is_older(
    input logic [SEQ_NUM_BITS-1:0] a,
    input logic [SEQ_NUM_BITS-1:0] b
  );
    logic [EPOCH_BITS-1:0] a_epoch;
    logic [EPOCH_BITS-1:0] b_epoch;
    logic [EPOCH_BITS:0] a_adj;
    logic [EPOCH_BITS:0] b_adj;
    a_epoch = a[SEQ_NUM_BITS-1 -: EPOCH_BITS];
    b_epoch = b[SEQ_NUM_BITS-1 -: EPOCH_BITS];
    // lap bit set when the epoch wrapped past the tail
    a_adj = {a_epoch < curr_tail_epoch, a_epoch};
    b_adj = {b_epoch < curr_tail_epoch, b_epoch};
    if (a_adj != b_adj) begin
      return a_adj < b_adj;
    end
    // same epoch, remainder decides; equal numbers are not older
    return a[SEQ_NUM_BITS-EPOCH_BITS-1:0] < b[SEQ_NUM_BITS-EPOCH_BITS-1:0];
  endfunction

  // allocator side
  modport tail_owner (output curr_tail_epoch);

  // tracker side, read epoch plus the compare
  modport age_user (input curr_tail_epoch, import is_older);

endinterface

// ==== design/seq_num_alloc.sv ====
/*
  sequence-number allocator
  hands out numbers at the head, frees them in order at the tail,
  caps the live window and drives the tail epoch
*/

`timescale 1ns/1ps

module seq_num_alloc import seq_pkg::*; #(
  parameter int SEQ_NUM_BITS = $bits(seq_num_t),
  parameter int EPOCH_BITS = $bits(epoch_t)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    alloc_req,
  input  logic                    commit_req,
  output logic                    alloc_ack,
  output logic [SEQ_NUM_BITS-1:0] alloc_seq_num,
  output logic                    commit_ack,
  output logic [SEQ_NUM_BITS-1:0] commit_seq_num,
  output logic                    full,
  output logic                    empty,
  seq_num_age_intf.tail_owner     age
);

  // remainder width below the epoch
  localparam int REM_W = SEQ_NUM_BITS - EPOCH_BITS;
  // occupancy cap, one epoch short of the whole number space
  localparam logic [SEQ_NUM_BITS-1:0] LIVE_MAX =
    SEQ_NUM_BITS'((1 << SEQ_NUM_BITS) - (1 << REM_W));

  logic [SEQ_NUM_BITS-1:0] head;
  logic [SEQ_NUM_BITS-1:0] tail;
  // live numbers between tail and head
  logic [SEQ_NUM_BITS-1:0] count;

  // transaction fires on the edge its ack rises
  logic alloc_fire;
  logic commit_fire;

  assign full  = (count == LIVE_MAX);
  assign empty = (count == '0);

  // blocked while full or empty, retried every cycle
  assign alloc_fire  = alloc_req && !alloc_ack && !full;
  assign commit_fire = commit_req && !commit_ack && !empty;

  // tail epoch moves on the same edge as the tail
  assign age.curr_tail_epoch = tail[SEQ_NUM_BITS-1 -: EPOCH_BITS];

  // ----------------------------------------------------------
  // four-phase responders
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alloc_ack  <= 1'b0;
      commit_ack <= 1'b0;
    end else begin
      // rise on accept, fall once req is seen low
      if (alloc_fire) begin
        alloc_ack <= 1'b1;
      end else if (!alloc_req) begin
        alloc_ack <= 1'b0;
      end
      if (commit_fire) begin
        commit_ack <= 1'b1;
      end else if (!commit_req) begin
        commit_ack <= 1'b0;
      end
    end
  end

  // returned numbers, valid while ack is high
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      alloc_seq_num <= head;
    end
    if (commit_fire) begin
      commit_seq_num <= tail;
    end
  end

  // ----------------------------------------------------------
  // head, tail and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // both counters wrap modulo the number space
      if (alloc_fire) begin
        head <= head + 1'b1;
      end
      if (commit_fire) begin
        tail <= tail + 1'b1;
      end
      unique case ({alloc_fire, commit_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/seq_pkg.sv ====
/*
  sequence-number package
  widths, derived window sizes and payload types for the tracker
*/

package seq_pkg;

  // ----------------------------------------------------------
  // sequence-number geometry
  // ----------------------------------------------------------

  // full sequence-number width
  localparam int SEQ_NUM_BITS = 5;
  // epoch is the top slice of a sequence number
  localparam int EPOCH_BITS = 2;
  // remainder below the epoch
  localparam int REM_BITS = SEQ_NUM_BITS - EPOCH_BITS;

  // live window, all numbers minus one epoch's worth
  // keeps the head from reaching back into the tail's epoch
  localparam int MAX_INFLIGHT = (1 << SEQ_NUM_BITS) - (1 << REM_BITS);

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------

  typedef logic [SEQ_NUM_BITS-1:0] seq_num_t;
  typedef logic [EPOCH_BITS-1:0] epoch_t;

  // mispredict target address
  typedef logic [15:0] br_target_t;
  // exception cause code
  typedef logic [4:0] exc_cause_t;

endpackage

// ==== design/seq_report_if.sv ====
/*
  event report interface
  four-phase req/ack carrying a sequence number and a typed payload
*/

`timescale 1ns/1ps

interface seq_report_if import seq_pkg::*; #(
  parameter int SEQ_NUM_BITS = $bits(seq_num_t),
  parameter type payload_t = logic
) ();

  // handshake pair
  logic req;
  logic ack;

  // held stable by the reporter until ack rises
  logic [SEQ_NUM_BITS-1:0] seq_num;
  payload_t payload;

  // event source
  modport reporter (output req, output seq_num, output payload, input ack);

  // oldest-event tracker
  modport tracker (input req, input seq_num, input payload, output ack);

endinterface

// ==== design/seq_tracker_top.sv ====
/*
  sequence tracker top level
  allocator plus oldest-mispredict and oldest-exception trackers
*/

`timescale 1ns/1ps

module seq_tracker_top import seq_pkg::*; #(
  parameter int SEQ_NUM_BITS = $bits(seq_num_t),
  parameter int EPOCH_BITS = $bits(epoch_t)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // allocate and commit
  input  logic                    alloc_req,
  output logic                    alloc_ack,
  output logic [SEQ_NUM_BITS-1:0] alloc_seq_num,
  input  logic                    commit_req,
  output logic                    commit_ack,
  output logic [SEQ_NUM_BITS-1:0] commit_seq_num,
  output logic                    full,
  output logic                    empty,
  // mispredict reports
  input  logic                    br_req,
  input  logic [SEQ_NUM_BITS-1:0] br_seq_num,
  input  br_target_t              br_target,
  output logic                    br_ack,
  output logic                    br_valid,
  output logic [SEQ_NUM_BITS-1:0] br_oldest_seq_num,
  output br_target_t              br_oldest_target,
  // exception reports
  input  logic                    exc_req,
  input  logic [SEQ_NUM_BITS-1:0] exc_seq_num,
  input  exc_cause_t              exc_cause,
  output logic                    exc_ack,
  output logic                    exc_valid,
  output logic [SEQ_NUM_BITS-1:0] exc_oldest_seq_num,
  output exc_cause_t              exc_oldest_cause,
  // clears both trackers
  input  logic                    flush
);

  // ----------------------------------------------------------
  // interfaces
  // ----------------------------------------------------------

  seq_num_age_intf #(.SEQ_NUM_BITS(SEQ_NUM_BITS), .EPOCH_BITS(EPOCH_BITS)) age_if ();

  seq_report_if #(.SEQ_NUM_BITS(SEQ_NUM_BITS), .payload_t(br_target_t)) br_rpt ();
  seq_report_if #(.SEQ_NUM_BITS(SEQ_NUM_BITS), .payload_t(exc_cause_t)) exc_rpt ();

  // reporter side comes straight from the pins
  assign br_rpt.req     = br_req;
  assign br_rpt.seq_num = br_seq_num;
  assign br_rpt.payload = br_target;
  assign br_ack         = br_rpt.ack;

  assign exc_rpt.req     = exc_req;
  assign exc_rpt.seq_num = exc_seq_num;
  assign exc_rpt.payload = exc_cause;
  assign exc_ack         = exc_rpt.ack;

  // ----------------------------------------------------------
  // allocator, owns the tail epoch
  // ----------------------------------------------------------

  seq_num_alloc #(.SEQ_NUM_BITS(SEQ_NUM_BITS), .EPOCH_BITS(EPOCH_BITS)) i_seq_num_alloc (
    .clk            (clk),
    .rst_n          (rst_n),
    .alloc_req      (alloc_req),
    .commit_req     (commit_req),
    .alloc_ack      (alloc_ack),
    .alloc_seq_num  (alloc_seq_num),
    .commit_ack     (commit_ack),
    .commit_seq_num (commit_seq_num),
    .full           (full),
    .empty          (empty),
    .age            (age_if.tail_owner)
  );

  // ----------------------------------------------------------
  // trackers, one per payload kind
  // ----------------------------------------------------------

  oldest_tracker #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS),
    .EPOCH_BITS   (EPOCH_BITS),
    .payload_t    (br_target_t)
  ) i_br_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .rpt            (br_rpt.tracker),
    .age            (age_if.age_user),
    .valid          (br_valid),
    .oldest_seq_num (br_oldest_seq_num),
    .oldest_payload (br_oldest_target)
  );

  oldest_tracker #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS),
    .EPOCH_BITS   (EPOCH_BITS),
    .payload_t    (exc_cause_t)
  ) i_exc_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .rpt            (exc_rpt.tracker),
    .age            (age_if.age_user),
    .valid          (exc_valid),
    .oldest_seq_num (exc_oldest_seq_num),
    .oldest_payload (exc_oldest_cause)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sequence tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

# compile, then run; logs land in the project root
verilator --binary --timing --assert -Wno-fatal \
  --top-module seq_tracker_tb -f sources.f -o seq_tracker_sim > build.log 2>&1 &&
  ./obj_dir/seq_tracker_sim > sim.log 2>&1 ||
  echo "build or simulation exited with an error, see build.log and sim.log"

# the pass line in the log decides the result
grep -qx "TEST PASS" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== sources.f ====
design/seq_pkg.sv
design/seq_num_age_intf.sv
design/seq_report_if.sv
design/seq_num_alloc.sv
design/oldest_tracker.sv
design/seq_tracker_top.sv
testbench/seq_tracker_props.sv
testbench/seq_tracker_tb.sv

// ==== testbench/seq_tracker_props.sv ====
/*
  sequence tracker handshake properties
  four-phase ack timing and reset state, bound into the top level
*/

`timescale 1ns/1ps

module seq_tracker_props (
  input logic clk,
  input logic rst_n,
  input logic alloc_req,
  input logic alloc_ack,
  input logic commit_req,
  input logic commit_ack,
  input logic br_req,
  input logic br_ack,
  input logic exc_req,
  input logic exc_ack,
  input logic full,
  input logic empty,
  input logic br_valid,
  input logic exc_valid
);

  // ----------------------------------------------------------
  // ack rises only on a sampled req
  // ----------------------------------------------------------
  a_alloc_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(alloc_ack) |-> $past(alloc_req)) else $error("alloc_ack rose without req");
  a_commit_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(commit_ack) |-> $past(commit_req)) else $error("commit_ack rose without req");
  a_br_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(br_ack) |-> $past(br_req)) else $error("br_ack rose without req");
  a_exc_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(exc_ack) |-> $past(exc_req)) else $error("exc_ack rose without req");

  // ----------------------------------------------------------
  // ack falls only once req is low
  // ----------------------------------------------------------
  a_alloc_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(alloc_ack) |-> !$past(alloc_req)) else $error("alloc_ack fell with req high");
  a_commit_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(commit_ack) |-> !$past(commit_req)) else $error("commit_ack fell with req high");
  a_br_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(br_ack) |-> !$past(br_req)) else $error("br_ack fell with req high");
  a_exc_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(exc_ack) |-> !$past(exc_req)) else $error("exc_ack fell with req high");

  // one-cycle ack when nothing blocks
  a_alloc_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (alloc_req && !alloc_ack && !full) |=> alloc_ack) else $error("alloc_ack late");
  a_commit_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (commit_req && !commit_ack && !empty) |=> commit_ack) else $error("commit_ack late");
  a_br_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (br_req && !br_ack) |=> br_ack) else $error("br_ack late");
  a_exc_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (exc_req && !exc_ack) |=> exc_ack) else $error("exc_ack late");

  // state right after a reset cycle
  a_reset: assert property (@(posedge clk) !rst_n |=>
    (!alloc_ack && !commit_ack && !br_ack && !exc_ack && !br_valid && !exc_valid
     && !full && empty)) else $error("outputs not cleared by reset");

endmodule

bind seq_tracker_top seq_tracker_props i_seq_tracker_props (.*);

// ==== testbench/seq_tracker_tb.sv ====
/*
  sequence tracker testbench
  drives allocate, commit, report and flush traffic and checks the DUT
  against a reference model of the counters and the epoch age rule
*/

`timescale 1ns/1ps

module seq_tracker_tb import seq_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  // tests run roughly 500 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int SEQ_SPAN = 1 << SEQ_NUM_BITS;
  localparam int EPOCH_SPAN = 1 << EPOCH_BITS;
  localparam int REM_SPAN = 1 << REM_BITS;

  logic       clk;
  logic       rst_n;
  logic       alloc_req;
  logic       alloc_ack;
  seq_num_t   alloc_seq_num;
  logic       commit_req;
  logic       commit_ack;
  seq_num_t   commit_seq_num;
  logic       full;
  logic       empty;
  logic       br_req;
  seq_num_t   br_seq_num;
  br_target_t br_target;
  logic       br_ack;
  logic       br_valid;
  seq_num_t   br_oldest_seq_num;
  br_target_t br_oldest_target;
  logic       exc_req;
  seq_num_t   exc_seq_num;
  exc_cause_t exc_cause;
  logic       exc_ack;
  logic       exc_valid;
  seq_num_t   exc_oldest_seq_num;
  exc_cause_t exc_oldest_cause;
  logic       flush;

  int errors = 0;
  int prop_errors = 0;
  int cycles = 0;

  // ----------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------
  int         model_head = 0;
  int         model_tail = 0;
  int         model_count = 0;
  bit         br_model_valid = 1'b0;
  seq_num_t   br_model_seq;
  br_target_t br_model_target;
  bit         exc_model_valid = 1'b0;
  seq_num_t   exc_model_seq;
  exc_cause_t exc_model_cause;

  seq_tracker_top #(.SEQ_NUM_BITS(SEQ_NUM_BITS), .EPOCH_BITS(EPOCH_BITS)) i_seq_tracker_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // occupancy flags are exclusive
  assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
    else begin
      $display("mismatch at %0t: full and empty high together", $time);
      prop_errors++;
    end

  task automatic check_eq(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // inputs move 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // epoch rule, epochs behind the tail count one lap later
  function automatic bit ref_older(input seq_num_t a, input seq_num_t b);
    int tail_ep;
    int a_ep;
    int b_ep;
    tail_ep = model_tail / REM_SPAN;
    a_ep = int'(a) / REM_SPAN;
    b_ep = int'(b) / REM_SPAN;
    if (a_ep < tail_ep) begin
      a_ep += EPOCH_SPAN;
    end
    if (b_ep < tail_ep) begin
      b_ep += EPOCH_SPAN;
    end
    if (a_ep != b_ep) begin
      return a_ep < b_ep;
    end
    return (int'(a) % REM_SPAN) < (int'(b) % REM_SPAN);
  endfunction

  // somewhere between tail and head
  function automatic seq_num_t random_live_seq();
    int offset;
    offset = int'($urandom % 32'(model_count));
    return seq_num_t'(model_tail + offset);
  endfunction

  task automatic check_flags();
    check_eq("full", full, model_count == MAX_INFLIGHT);
    check_eq("empty", empty, model_count == 0);
  endtask

  // ----------------------------------------------------------
  // handshakes, finish_* runs once ack is seen high
  // ----------------------------------------------------------

  task automatic finish_alloc();
    check_eq("alloc_seq_num", alloc_seq_num, model_head);
    model_head = (model_head + 1) % SEQ_SPAN;
    model_count++;
    alloc_req = 1'b0;
    do step(); while (alloc_ack);
  endtask

  task automatic finish_commit();
    check_eq("commit_seq_num", commit_seq_num, model_tail);
    model_tail = (model_tail + 1) % SEQ_SPAN;
    model_count--;
    commit_req = 1'b0;
    do step(); while (commit_ack);
  endtask

  task automatic do_alloc();
    alloc_req = 1'b1;
    do step(); while (!alloc_ack);
    finish_alloc();
    check_flags();
  endtask

  task automatic do_commit();
    commit_req = 1'b1;
    do step(); while (!commit_ack);
    finish_commit();
    check_flags();
  endtask

  task automatic send_br(input seq_num_t sn, input br_target_t tgt);
    br_req = 1'b1;
    br_seq_num = sn;
    br_target = tgt;
    do step(); while (!br_ack);
    br_req = 1'b0;
    do step(); while (br_ack);
    if (!br_model_valid || ref_older(sn, br_model_seq)) begin
      br_model_valid = 1'b1;
      br_model_seq = sn;
      br_model_target = tgt;
    end
    check_eq("br_valid", br_valid, 1);
    check_eq("br_oldest_seq_num", br_oldest_seq_num, br_model_seq);
    check_eq("br_oldest_target", br_oldest_target, br_model_target);
  endtask

  task automatic send_exc(input seq_num_t sn, input exc_cause_t cause);
    exc_req = 1'b1;
    exc_seq_num = sn;
    exc_cause = cause;
    do step(); while (!exc_ack);
    exc_req = 1'b0;
    do step(); while (exc_ack);
    if (!exc_model_valid || ref_older(sn, exc_model_seq)) begin
      exc_model_valid = 1'b1;
      exc_model_seq = sn;
      exc_model_cause = cause;
    end
    check_eq("exc_valid", exc_valid, 1);
    check_eq("exc_oldest_seq_num", exc_oldest_seq_num, exc_model_seq);
    check_eq("exc_oldest_cause", exc_oldest_cause, exc_model_cause);
  endtask

  task automatic report_burst(input int pairs);
    repeat (pairs) begin
      send_br(random_live_seq(), br_target_t'($urandom));
      send_exc(random_live_seq(), exc_cause_t'($urandom));
    end
  endtask

  // valids drop on the edge after the pulse
  task automatic pulse_flush();
    flush = 1'b1;
    step();
    flush = 1'b0;
    check_eq("br_valid after flush", br_valid, 0);
    check_eq("exc_valid after flush", exc_valid, 0);
    br_model_valid = 1'b0;
    exc_model_valid = 1'b0;
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------

  initial begin
    void'($urandom(32'h029f_60d8));
    rst_n = 1'b0;
    alloc_req = 1'b0;
    commit_req = 1'b0;
    br_req = 1'b0;
    br_seq_num = '0;
    br_target = '0;
    exc_req = 1'b0;
    exc_seq_num = '0;
    exc_cause = '0;
    flush = 1'b0;
    repeat (RESET_CYCLES) step();
    rst_n = 1'b1;
    check_eq("empty after reset", empty, 1);
    check_eq("full after reset", full, 0);
    check_eq("br_valid after reset", br_valid, 0);
    check_eq("exc_valid after reset", exc_valid, 0);

    // commit on empty waits for an allocation
    commit_req = 1'b1;
    repeat (3) begin
      step();
      check_eq("commit_ack while empty", commit_ack, 0);
    end
    alloc_req = 1'b1;
    do step(); while (!alloc_ack);
    finish_alloc();
    while (!commit_ack) step();
    finish_commit();
    check_flags();

    // wrap both counters, tail epoch runs through every value
    repeat (SEQ_SPAN + 4) begin
      do_alloc();
      do_commit();
    end

    // fill the window, then hold a blocked allocation
    repeat (MAX_INFLIGHT) do_alloc();
    alloc_req = 1'b1;
    repeat (3) begin
      step();
      check_eq("alloc_ack while full", alloc_ack, 0);
    end
    commit_req = 1'b1;
    do step(); while (!commit_ack);
    finish_commit();
    while (!alloc_ack) step();
    finish_alloc();
    check_flags();

    // reports across epoch moves, window slides one epoch per round
    for (int round = 0; round < 4; round++) begin
      pulse_flush();
      report_burst(4);
      repeat (REM_SPAN) do_commit();
      report_burst(4);
      repeat (REM_SPAN) do_alloc();
    end

    $display("run done: %0d mismatches, %0d protocol errors", errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
